// File: src/multiCycleMips_cfg.svh
`ifndef MULTI_CYCLE_MIPS_CFG_SVH
`define MULTI_CYCLE_MIPS_CFG_SVH

// Data and address word width
`define XLEN 32

// Architectural register file
`define REG_COUNT 32
`define REG_ADDR_W 5

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Register written by jal
`define LINK_REG 31

`endif

// File: src/mipsPkg.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

package mipsPkg;

   // ==============================
   // ALU and datapath selectors
   // ==============================

   typedef enum logic [3:0] {
      aluAdd  = 4'b0000,
      aluSub  = 4'b0001,
      aluSlt  = 4'b0010,
      aluSltu = 4'b0011,
      aluAnd  = 4'b0100,
      aluOr   = 4'b0101,
      aluXor  = 4'b0110,
      aluNor  = 4'b0111,
      aluAddu = 4'b1000,
      aluSubu = 4'b1001,
      aluLui  = 4'b1011
   } aluOpE;

   typedef enum logic [1:0] {srcBReg, srcBFour, srcBImm, srcBImmSh2} aluSrcBE;
   typedef enum logic [1:0] {pcAlu, pcJump, pcRegA} pcSrcE;
   typedef enum logic [1:0] {addrPc, addrAlu, addrJump, addrRegA} addrSrcE;
   typedef enum logic [1:0] {dstRt, dstRd, dstLink} regDstE;
   typedef enum logic [1:0] {wbAlu, wbMdr, wbPc} wbSrcE;

   // ==============================
   // Instruction word
   // ==============================

   typedef struct packed {
      logic [5:0]             opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [`REG_ADDR_W-1:0] rd;
      logic [4:0]             shamt;
      logic [5:0]             funct;
   } rFmtT;

   // Low 26 bits double as the jump index
   typedef struct packed {
      logic [5:0]             opcode;
      logic [`REG_ADDR_W-1:0] rs;
      logic [`REG_ADDR_W-1:0] rt;
      logic [15:0]            imm;
   } iFmtT;

   typedef union packed {
      rFmtT r;
      iFmtT i;
   } instrU;

   // ==============================
   // Control bundle and memory port
   // ==============================

   typedef struct packed {
      aluOpE   aluOp;
      logic    aluSelA;   // 1 picks A, 0 picks PC
      aluSrcBE aluSrcB;
      logic    sgnExt;
      pcSrcE   pcSrc;
      addrSrcE addrSrc;
      regDstE  regDst;
      wbSrcE   wbSrc;
      logic    pcWrite;
      logic    irWrite;
      logic    aWrite;
      logic    bWrite;
      logic    mdrWrite;
      logic    marWrite;
      logic    regWrite;
      logic    setRead;
      logic    clrRead;
      logic    setWrite;
      logic    clrWrite;
   } ctrlT;

   typedef struct packed {
      logic [`XLEN-1:0] addr;
      logic [`XLEN-1:0] writeData;
      logic             read;
      logic             write;
   } memReqT;

endpackage

`default_nettype wire

// File: src/mipsAlu.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

module mipsAlu (
   input  mipsPkg::aluOpE    op,
   input  logic [`XLEN-1:0]  a,
   input  logic [`XLEN-1:0]  b,
   output logic [`XLEN-1:0]  result,
   output logic              zero
);

   logic             doSub;
   logic [`XLEN-1:0] bIn;
   logic [`XLEN:0]   sum;
   logic             overflow;
   logic             lessSigned;
   logic             lessUnsigned;

   // Compares run through the subtractor too
   assign doSub = (op == mipsPkg::aluSub) || (op == mipsPkg::aluSubu) ||
                  (op == mipsPkg::aluSlt) || (op == mipsPkg::aluSltu);

   assign bIn = doSub ? ~b : b;
   assign sum = {1'b0, a} + {1'b0, bIn} + {{`XLEN{1'b0}}, doSub};

   assign overflow = (a[`XLEN-1] == bIn[`XLEN-1]) && (sum[`XLEN-1] != a[`XLEN-1]);
   assign lessSigned = overflow ^ sum[`XLEN-1];
   assign lessUnsigned = ~sum[`XLEN];   // No carry means a borrow

   always_comb begin
      case (op)
         mipsPkg::aluAdd, mipsPkg::aluAddu,
         mipsPkg::aluSub, mipsPkg::aluSubu: result = sum[`XLEN-1:0];
         mipsPkg::aluSlt:  result = {{(`XLEN-1){1'b0}}, lessSigned};
         mipsPkg::aluSltu: result = {{(`XLEN-1){1'b0}}, lessUnsigned};
         mipsPkg::aluAnd:  result = a & b;
         mipsPkg::aluOr:   result = a | b;
         mipsPkg::aluXor:  result = a ^ b;
         mipsPkg::aluNor:  result = ~(a | b);
         mipsPkg::aluLui:  result = b << 16;
         default:          result = '0;
      endcase
   end

   assign zero = (result == '0);

endmodule

`default_nettype wire

// File: src/regFile.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

module regFile (
   input  logic                   clk,
   input  logic                   write,
   input  logic [`REG_ADDR_W-1:0] writeAddr,
   input  logic [`XLEN-1:0]       writeData,
   input  logic [`REG_ADDR_W-1:0] readAddr1,
   input  logic [`REG_ADDR_W-1:0] readAddr2,
   output logic [`XLEN-1:0]       readData1,
   output logic [`XLEN-1:0]       readData2
);

   logic [`XLEN-1:0] regs [`REG_COUNT];

   always_ff @(posedge clk) begin
      if (write && (writeAddr != '0)) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Register zero is never stored and reads as zero
   assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
   assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

`default_nettype wire

// File: src/mipsController.sv
`default_nettype none

module mipsController (
   input  logic            clk,
   input  logic            reset,
   input  mipsPkg::instrU  instr,
   input  logic            zero,
   output mipsPkg::ctrlT   ctrl
);

   localparam logic [5:0] opRType = 6'b000000;
   localparam logic [5:0] opJ     = 6'b000010;
   localparam logic [5:0] opJal   = 6'b000011;
   localparam logic [5:0] opBeq   = 6'b000100;
   localparam logic [5:0] opBne   = 6'b000101;
   localparam logic [5:0] opLw    = 6'b100011;
   localparam logic [5:0] opSw    = 6'b101011;
   localparam logic [5:0] fnJr    = 6'b001000;

   typedef enum logic [4:0] {
      stReset, stFetch1, stFetch2, stFetch3, stDecode,
      stExAluR, stAluI,
      stLw1, stLw2, stLw3, stLw4, stLw5,
      stSw1, stSw2, stSw3,
      stBranch1, stBranch2,
      stJump, stJumpLink, stJumpReg
   } stateE;

   stateE state;
   stateE nextState;
   logic  doFetch;

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= stReset;
      end else begin
         state <= nextState;
      end
   end

   // ==============================
   // Per-state control bundle
   // ==============================

   always_comb begin
      ctrl = '0;
      nextState = stFetch1;
      doFetch = 1'b0;

      case (state)
         stReset: doFetch = 1'b1;   // Also refetch after a taken branch
         stFetch1: nextState = stFetch2;
         stFetch2: nextState = stFetch3;
         stFetch3: begin
            ctrl.irWrite = 1'b1;
            ctrl.clrRead = 1'b1;
            ctrl.aluSrcB = mipsPkg::srcBFour;   // PC + 4
            ctrl.pcWrite = 1'b1;
            nextState = stDecode;
         end
         stDecode: begin
            ctrl.aWrite = 1'b1;
            ctrl.bWrite = 1'b1;
            case (instr.i.opcode)
               opRType: nextState = (instr.r.funct == fnJr) ? stJumpReg : stExAluR;
               opLw: nextState = stLw1;
               opSw: nextState = stSw1;
               opBeq, opBne: nextState = stBranch1;
               opJ: nextState = stJump;
               opJal: nextState = stJumpLink;
               default: begin
                  if (instr.i.opcode[5:3] == 3'b001) begin
                     nextState = stAluI;
                  end else begin
                     doFetch = 1'b1;   // Unknown opcode
                  end
               end
            endcase
         end
         stExAluR: begin
            ctrl.aluSelA = 1'b1;
            ctrl.regDst = mipsPkg::dstRd;
            ctrl.regWrite = 1'b1;
            doFetch = 1'b1;
            case (instr.r.funct)
               6'b100000: ctrl.aluOp = mipsPkg::aluAdd;
               6'b100001: ctrl.aluOp = mipsPkg::aluAddu;
               6'b100010: ctrl.aluOp = mipsPkg::aluSub;
               6'b100011: ctrl.aluOp = mipsPkg::aluSubu;
               6'b100100: ctrl.aluOp = mipsPkg::aluAnd;
               6'b100101: ctrl.aluOp = mipsPkg::aluOr;
               6'b100110: ctrl.aluOp = mipsPkg::aluXor;
               6'b100111: ctrl.aluOp = mipsPkg::aluNor;
               6'b101010: ctrl.aluOp = mipsPkg::aluSlt;
               6'b101011: ctrl.aluOp = mipsPkg::aluSltu;
               default: ctrl.regWrite = 1'b0;
            endcase
         end
         stAluI: begin
            ctrl.aluSelA = 1'b1;
            ctrl.aluSrcB = mipsPkg::srcBImm;
            ctrl.regWrite = 1'b1;
            doFetch = 1'b1;
            case (instr.i.opcode[2:0])
               3'b000: begin
                  ctrl.aluOp = mipsPkg::aluAdd;
                  ctrl.sgnExt = 1'b1;
               end
               3'b001: begin
                  ctrl.aluOp = mipsPkg::aluAddu;
                  ctrl.sgnExt = 1'b1;
               end
               3'b010: begin
                  ctrl.aluOp = mipsPkg::aluSlt;
                  ctrl.sgnExt = 1'b1;
               end
               3'b011: ctrl.aluOp = mipsPkg::aluSltu;
               3'b100: ctrl.aluOp = mipsPkg::aluAnd;
               3'b101: ctrl.aluOp = mipsPkg::aluOr;
               3'b110: ctrl.aluOp = mipsPkg::aluXor;
               default: ctrl.aluOp = mipsPkg::aluLui;
            endcase
         end
         stLw1, stSw1: begin
            ctrl.aluSelA = 1'b1;   // A + sign-extended offset
            ctrl.aluSrcB = mipsPkg::srcBImm;
            ctrl.sgnExt = 1'b1;
            ctrl.addrSrc = mipsPkg::addrAlu;
            ctrl.marWrite = 1'b1;
            ctrl.setRead = (state == stLw1);
            nextState = (state == stLw1) ? stLw2 : stSw2;
         end
         stLw2: nextState = stLw3;
         stLw3: nextState = stLw4;
         stLw4: begin
            ctrl.mdrWrite = 1'b1;
            ctrl.clrRead = 1'b1;
            nextState = stLw5;
         end
         stLw5: begin
            ctrl.wbSrc = mipsPkg::wbMdr;
            ctrl.regWrite = 1'b1;
            doFetch = 1'b1;
         end
         stSw2: begin
            ctrl.setWrite = 1'b1;
            nextState = stSw3;
         end
         stSw3: begin
            ctrl.clrWrite = 1'b1;
            doFetch = 1'b1;
         end
         // Fetch of PC + 4 starts here and is dropped on a taken branch
         stBranch1: begin
            ctrl.aluSelA = 1'b1;
            ctrl.aluOp = mipsPkg::aluSub;
            doFetch = 1'b1;
            nextState = (zero ^ instr.i.opcode[0]) ? stBranch2 : stFetch1;
         end
         stBranch2: begin
            ctrl.aluSrcB = mipsPkg::srcBImmSh2;
            ctrl.sgnExt = 1'b1;
            ctrl.pcWrite = 1'b1;
            ctrl.clrRead = 1'b1;
            nextState = stReset;
         end
         stJump, stJumpLink: begin
            ctrl.pcSrc = mipsPkg::pcJump;
            ctrl.pcWrite = 1'b1;
            ctrl.addrSrc = mipsPkg::addrJump;
            ctrl.setRead = 1'b1;
            ctrl.marWrite = 1'b1;
            ctrl.regDst = mipsPkg::dstLink;
            ctrl.wbSrc = mipsPkg::wbPc;   // PC already holds jal + 4
            ctrl.regWrite = (state == stJumpLink);
         end
         stJumpReg: begin
            ctrl.pcSrc = mipsPkg::pcRegA;
            ctrl.pcWrite = 1'b1;
            ctrl.addrSrc = mipsPkg::addrRegA;
            ctrl.setRead = 1'b1;
            ctrl.marWrite = 1'b1;
         end
         default: doFetch = 1'b1;
      endcase

      if (doFetch) begin
         ctrl.addrSrc = mipsPkg::addrPc;
         ctrl.setRead = 1'b1;
         ctrl.marWrite = 1'b1;
      end
   end

endmodule

`default_nettype wire

// File: src/coreDatapath.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

module coreDatapath (
   input  logic              clk,
   input  logic              reset,
   input  mipsPkg::ctrlT     ctrl,
   input  logic [`XLEN-1:0]  memReadData,
   output mipsPkg::memReqT   memReq,
   output mipsPkg::instrU    instr,
   output logic              zero
);

   logic [`XLEN-1:0]       pc;
   logic [`XLEN-1:0]       mar;
   logic [`XLEN-1:0]       mdr;
   logic [`XLEN-1:0]       regA;
   logic [`XLEN-1:0]       regB;
   mipsPkg::instrU         ir;
   logic                   readFlag;
   logic                   writeFlag;

   logic [`XLEN-1:0]       rfData1;
   logic [`XLEN-1:0]       rfData2;
   logic [`XLEN-1:0]       extImm;
   logic [`XLEN-1:0]       aluA;
   logic [`XLEN-1:0]       aluB;
   logic [`XLEN-1:0]       aluResult;
   logic [`XLEN-1:0]       jumpTarget;
   logic [`XLEN-1:0]       nextPc;
   logic [`XLEN-1:0]       nextMar;
   logic [`REG_ADDR_W-1:0] wbAddr;
   logic [`XLEN-1:0]       wbData;

   // ==============================
   // Registers
   // ==============================

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= `RESET_PC;
         readFlag <= 1'b0;
         writeFlag <= 1'b0;
      end else begin
         if (ctrl.pcWrite) begin
            pc <= nextPc;
         end
         if (ctrl.clrRead) begin
            readFlag <= 1'b0;
         end else if (ctrl.setRead) begin
            readFlag <= 1'b1;
         end
         if (ctrl.clrWrite) begin
            writeFlag <= 1'b0;
         end else if (ctrl.setWrite) begin
            writeFlag <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (ctrl.irWrite) ir <= memReadData;
      if (ctrl.mdrWrite) mdr <= memReadData;
      if (ctrl.marWrite) mar <= nextMar;
      if (ctrl.aWrite) regA <= rfData1;
      if (ctrl.bWrite) regB <= rfData2;
   end

   // ==============================
   // Operands and selection
   // ==============================

   assign extImm = ctrl.sgnExt ? {{(`XLEN-16){ir.i.imm[15]}}, ir.i.imm}
                               : {{(`XLEN-16){1'b0}}, ir.i.imm};

   // Upper PC bits with the 26-bit index
   assign jumpTarget = {pc[`XLEN-1:28], ir.i.rs, ir.i.rt, ir.i.imm, 2'b00};

   assign aluA = ctrl.aluSelA ? regA : pc;

   always_comb begin
      case (ctrl.aluSrcB)
         mipsPkg::srcBReg:  aluB = regB;
         mipsPkg::srcBFour: aluB = `XLEN'(4);
         mipsPkg::srcBImm:  aluB = extImm;
         default:           aluB = extImm << 2;
      endcase
   end

   always_comb begin
      case (ctrl.pcSrc)
         mipsPkg::pcJump: nextPc = jumpTarget;
         mipsPkg::pcRegA: nextPc = regA;
         default:         nextPc = aluResult;
      endcase
      case (ctrl.addrSrc)
         mipsPkg::addrAlu:  nextMar = aluResult;
         mipsPkg::addrJump: nextMar = jumpTarget;
         mipsPkg::addrRegA: nextMar = regA;
         default:           nextMar = pc;
      endcase
      case (ctrl.regDst)
         mipsPkg::dstRd:   wbAddr = ir.r.rd;
         mipsPkg::dstLink: wbAddr = `REG_ADDR_W'(`LINK_REG);
         default:          wbAddr = ir.i.rt;
      endcase
      case (ctrl.wbSrc)
         mipsPkg::wbMdr: wbData = mdr;
         mipsPkg::wbPc:  wbData = pc;
         default:        wbData = aluResult;
      endcase
   end

   regFile rf (
      .clk(clk),
      .write(ctrl.regWrite),
      .writeAddr(wbAddr),
      .writeData(wbData),
      .readAddr1(ir.r.rs),
      .readAddr2(ir.r.rt),
      .readData1(rfData1),
      .readData2(rfData2)
   );

   mipsAlu alu (
      .op(ctrl.aluOp),
      .a(aluA),
      .b(aluB),
      .result(aluResult),
      .zero(zero)
   );

   assign memReq = '{addr: mar, writeData: regB, read: readFlag, write: writeFlag};
   assign instr = ir;

endmodule

`default_nettype wire

// File: src/multiCycleMips.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

module multiCycleMips (
   input  logic              clk,
   input  logic              reset,
   input  logic [`XLEN-1:0]  memReadData,
   output mipsPkg::memReqT   memReq
);

   mipsPkg::ctrlT  ctrl;
   mipsPkg::instrU instr;
   logic           aluZero;

   // ==============================
   // Controller
   // ==============================

   mipsController controller (
      .clk(clk),
      .reset(reset),
      .instr(instr),
      .zero(aluZero),
      .ctrl(ctrl)
   );

   // ==============================
   // Datapath and memory port
   // ==============================

   coreDatapath datapath (
      .clk(clk),
      .reset(reset),
      .ctrl(ctrl),
      .memReadData(memReadData),
      .memReq(memReq),
      .instr(instr),
      .zero(aluZero)
   );

endmodule

`default_nettype wire

// File: tests/multiCycleMips_asserts.sv
`default_nettype none

module multiCycleMips_asserts (
   input logic            clk,
   input logic            reset,
   input mipsPkg::memReqT memReq
);

   // ==============================
   // Memory port rules
   // ==============================

   readWriteExclusive: assert property (@(posedge clk) disable iff (reset)
      !(memReq.read && memReq.write))
      else $error("read and write strobes high together");

   // Strobes come out of reset low
   strobesLowAfterReset: assert property (@(posedge clk)
      $past(reset) |-> (!memReq.read && !memReq.write))
      else $error("memory strobe high right after reset");

   writeSingleCycle: assert property (@(posedge clk) disable iff (reset)
      $rose(memReq.write) |=> !memReq.write)
      else $error("write strobe held longer than one cycle");

   alignedAddress: assert property (@(posedge clk) disable iff (reset)
      (memReq.read || memReq.write) |-> (memReq.addr[1:0] == 2'b00))
      else $error("memory address not word aligned");

endmodule

bind multiCycleMips multiCycleMips_asserts portChecks (
   .clk(clk),
   .reset(reset),
   .memReq(memReq)
);

`default_nettype wire

// File: tests/multiCycleMips_tb.sv
`default_nettype none

`include "multiCycleMips_cfg.svh"

module multiCycleMips_tb;

   localparam logic [31:0] doneAddr = 32'h0000_03FC;
   localparam int dataBase = 'h80;   // Word index of random data

   logic clk;
   logic reset;
   logic [`XLEN-1:0] memReadData;
   mipsPkg::memReqT memReq;

   logic [31:0] mem [256];
   logic [31:0] expAddr [$];
   logic [31:0] expData [$];
   int progPtr;
   int resOff;
   int mismatchErrors;
   int otherErrors;
   int cycles;
   logic doneSeen;

   multiCycleMips UUT (
      .clk(clk),
      .reset(reset),
      .memReadData(memReadData),
      .memReq(memReq)
   );

   always #50 clk = ~clk;

   // ==============================
   // Memory model
   // ==============================

   // Data only while a read is pending
   assign memReadData = memReq.read ? mem[memReq.addr[9:2]] : 'x;

   always @(negedge clk) begin
      if (!reset && memReq.write) begin
         mem[memReq.addr[9:2]] = memReq.writeData;
      end
   end

   // ==============================
   // Program assembly
   // ==============================

   function automatic logic [31:0] rInstr(input logic [5:0] funct, input logic [4:0] rd,
                                          input logic [4:0] rs, input logic [4:0] rt);
      return {6'h00, rs, rt, rd, 5'd0, funct};
   endfunction

   function automatic logic [31:0] iInstr(input logic [5:0] op, input logic [4:0] rt,
                                          input logic [4:0] rs, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jInstr(input logic [5:0] op, input logic [25:0] index);
      return {op, index};
   endfunction

   task automatic put(input logic [31:0] word);
      mem[progPtr] = word;
      progPtr++;
   endtask

   task automatic storeResult(input logic [4:0] rt);
      put(iInstr(6'h2B, rt, 5'd0, 16'(resOff)));
      resOff += 4;
   endtask

   task automatic buildProgram();
      logic [5:0] rFuncts [10];
      int k;
      rFuncts = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B};
      progPtr = 0;
      resOff = 'h300;
      put(iInstr(6'h23, 5'd1, 5'd0, 16'h0200));   // Random operands
      put(iInstr(6'h23, 5'd2, 5'd0, 16'h0204));
      put(iInstr(6'h23, 5'd0, 5'd0, 16'h0208));   // Load into r0
      storeResult(5'd0);
      storeResult(5'd1);
      storeResult(5'd2);
      foreach (rFuncts[i]) begin
         put(rInstr(rFuncts[i], 5'd3, 5'd1, 5'd2));
         storeResult(5'd3);
      end
      put(rInstr(6'h2A, 5'd3, 5'd2, 5'd1));
      storeResult(5'd3);
      put(rInstr(6'h2B, 5'd3, 5'd2, 5'd1));
      storeResult(5'd3);
      put(iInstr(6'h08, 5'd4, 5'd1, 16'h8765));
      storeResult(5'd4);
      put(iInstr(6'h09, 5'd4, 5'd1, 16'h1234));
      storeResult(5'd4);
      put(iInstr(6'h0A, 5'd4, 5'd1, 16'hFFF0));
      storeResult(5'd4);
      put(iInstr(6'h0B, 5'd4, 5'd1, 16'h8000));
      storeResult(5'd4);
      put(iInstr(6'h0C, 5'd4, 5'd1, 16'hF0F0));
      storeResult(5'd4);
      put(iInstr(6'h0D, 5'd4, 5'd1, 16'h8001));
      storeResult(5'd4);
      put(iInstr(6'h0E, 5'd4, 5'd1, 16'hFFFF));
      storeResult(5'd4);
      put(iInstr(6'h0F, 5'd4, 5'd0, 16'hBEEF));
      storeResult(5'd4);
      // Branches over one store each
      put(iInstr(6'h04, 5'd1, 5'd1, 16'd1));
      storeResult(5'd1);
      storeResult(5'd2);
      put(iInstr(6'h05, 5'd1, 5'd1, 16'd1));
      storeResult(5'd3);
      put(iInstr(6'h04, 5'd2, 5'd1, 16'd1));
      storeResult(5'd1);
      put(iInstr(6'h05, 5'd2, 5'd1, 16'd1));
      storeResult(5'd2);
      k = progPtr;
      put(jInstr(6'h03, 26'(k + 3)));   // jal to subroutine
      storeResult(5'd31);
      put(jInstr(6'h02, 26'(k + 5)));
      storeResult(5'd1);   // Subroutine body
      put(rInstr(6'h08, 5'd0, 5'd31, 5'd0));
      put(iInstr(6'h0D, 5'd5, 5'd0, 16'h0D0E));
      put(iInstr(6'h2B, 5'd5, 5'd0, doneAddr[15:0]));
      put(jInstr(6'h02, 26'(progPtr)));   // Park
   endtask

   // ==============================
   // Reference model
   // ==============================

   function automatic void refRun();
      logic [31:0] r [32];
      logic [31:0] m [256];
      logic [31:0] pc;
      logic [31:0] ins;
      logic [31:0] nextPc;
      logic [31:0] sext;
      logic [31:0] zext;
      logic [31:0] ea;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic stop;
      foreach (r[i]) r[i] = '0;
      foreach (m[i]) m[i] = mem[i];
      pc = `RESET_PC;
      stop = 1'b0;
      for (int step = 0; step < 2000 && !stop; step++) begin
         ins = m[pc[9:2]];
         rs = ins[25:21];
         rt = ins[20:16];
         rd = ins[15:11];
         sext = {{16{ins[15]}}, ins[15:0]};
         zext = {16'h0000, ins[15:0]};
         ea = r[rs] + sext;
         nextPc = pc + 4;
         case (ins[31:26])
            6'h00: begin
               case (ins[5:0])
                  6'h20, 6'h21: r[rd] = r[rs] + r[rt];
                  6'h22, 6'h23: r[rd] = r[rs] - r[rt];
                  6'h24: r[rd] = r[rs] & r[rt];
                  6'h25: r[rd] = r[rs] | r[rt];
                  6'h26: r[rd] = r[rs] ^ r[rt];
                  6'h27: r[rd] = ~(r[rs] | r[rt]);
                  6'h2A: r[rd] = {31'd0, $signed(r[rs]) < $signed(r[rt])};
                  6'h2B: r[rd] = {31'd0, r[rs] < r[rt]};
                  6'h08: nextPc = r[rs];
                  default: ;
               endcase
            end
            6'h08, 6'h09: r[rt] = r[rs] + sext;
            6'h0A: r[rt] = {31'd0, $signed(r[rs]) < $signed(sext)};
            6'h0B: r[rt] = {31'd0, r[rs] < zext};
            6'h0C: r[rt] = r[rs] & zext;
            6'h0D: r[rt] = r[rs] | zext;
            6'h0E: r[rt] = r[rs] ^ zext;
            6'h0F: r[rt] = {ins[15:0], 16'h0000};
            6'h23: r[rt] = m[ea[9:2]];
            6'h2B: begin
               expAddr.push_back(ea);
               expData.push_back(r[rt]);
               m[ea[9:2]] = r[rt];
               stop = (ea == doneAddr);
            end
            6'h04: if (r[rs] == r[rt]) nextPc = pc + 4 + (sext << 2);
            6'h05: if (r[rs] != r[rt]) nextPc = pc + 4 + (sext << 2);
            6'h02: nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            6'h03: begin
               r[`LINK_REG] = pc + 4;
               nextPc = {nextPc[31:28], ins[25:0], 2'b00};
            end
            default: ;
         endcase
         r[0] = '0;
         pc = nextPc;
      end
   endfunction

   // ==============================
   // Checking
   // ==============================

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
      if (got !== expected) begin
         $display("Fail %s: got %h expected %h", name, got, expected);
         mismatchErrors++;
      end
   endtask

   always @(negedge clk) begin
      if (!reset && memReq.write) begin
         if (expAddr.size() == 0) begin
            $display("Store to %h seen but no store was expected", memReq.addr);
            otherErrors++;
         end else begin
            checkValue("memReq.addr", memReq.addr, expAddr.pop_front());
            checkValue("memReq.writeData", memReq.writeData, expData.pop_front());
         end
         if (memReq.addr == doneAddr) doneSeen = 1'b1;
      end
   end

   initial begin
      clk = 1'b0;
      reset = 1'b1;
      doneSeen = 1'b0;
      mismatchErrors = 0;
      otherErrors = 0;
      void'($urandom(32'h0fc13951));
      for (int i = 0; i < 256; i++) begin
         mem[i] = {8'hA5, 8'(i), ~8'(i), 8'(i)};
      end
      buildProgram();
      for (int i = 0; i < 3; i++) begin
         mem[dataBase + i] = $urandom();
      end
      mem[dataBase + 1][31] = ~mem[dataBase][31];   // Opposite signs tell slt from sltu
      refRun();
      repeat (10) @(posedge clk);
      #10 reset = 1'b0;
      cycles = 0;
      while (!doneSeen && cycles < 4000) begin
         @(posedge clk);
         cycles++;
      end
      if (!doneSeen) begin
         $display("Timeout: the program never stored to the done address");
         otherErrors++;
      end
      repeat (3) @(posedge clk);
      if (expAddr.size() != 0) begin
         $display("%0d expected stores never happened", expAddr.size());
         otherErrors++;
      end
      $display("Errors: %0d value mismatches, %0d other", mismatchErrors, otherErrors);
      if (mismatchErrors == 0 && otherErrors == 0) begin
         $display("Test OK");
      end else begin
         $display("Test FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: multiCycleMips.f
+incdir+src
src/mipsPkg.sv
src/mipsAlu.sv
src/regFile.sv
src/mipsController.sv
src/coreDatapath.sv
src/multiCycleMips.sv
tests/multiCycleMips_asserts.sv
tests/multiCycleMips_tb.sv

// File: run.sh
#!/bin/bash
# Build and run the multiCycleMips testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module multiCycleMips_tb -f multiCycleMips.f --Mdir obj_dir -o simv \
   && ./obj_dir/simv 2>&1 | tee sim.log \
   || { echo "Build or simulation failed"; exit 1; }

grep -q "Test FAILED" sim.log && exit 1 || exit 0
